// File: rw_gen_pkg.sv
/*
  Shared widths and types of the read/write request generator.
  Address and data are 32 bits. Item counts and the outstanding
  counter are 16 bits, so a job holds at most 65535 items.
*/
`default_nettype none

package rw_gen_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 16;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [COUNT_W-1:0] count_t;

    // ------------------------------------------------------------------------
    // Job configuration
    // ------------------------------------------------------------------------
    typedef struct packed {
        addr_t  base;
        addr_t  stride;
        count_t item_count;
        logic   mode_add;
        data_t  addend;
        // Hold done until every request is acknowledged
        logic   wait_ack;
    } rw_config_t;

    typedef struct packed {
        logic       valid;
        rw_config_t cfg;
    } config_packet_t;

    // ------------------------------------------------------------------------
    // Memory requests
    // ------------------------------------------------------------------------
    typedef struct packed {
        addr_t addr;
        data_t data;
    } mem_item_t;

    typedef struct packed {
        logic      valid;
        mem_item_t item;
    } mem_packet_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

    // Job FSM states
    typedef enum logic [3:0] {
        GEN_RESET,
        GEN_IDLE,
        GEN_SETUP_WAIT,
        GEN_SETUP_REQ,
        GEN_SETUP,
        GEN_START,
        GEN_BUSY,
        GEN_PAUSE,
        GEN_DRAIN,
        GEN_DONE
    } gen_state_e;

endpackage

`default_nettype wire

// File: rw_gen_sync_fifo.sv
/*
  Synchronous FIFO with registered read data. valid follows a read by
  one cycle. Writes into a full FIFO are dropped, reads of an empty one
  are ignored. prog_full is set at PROG_THRESH or more stored words.
*/
`timescale 1ns/100ps
`default_nettype none

module rw_gen_sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic [WIDTH-1:0]         din,
    input  logic                     wr_en,
    input  logic                     rd_en,
    output logic [WIDTH-1:0]         dout,
    output logic                     valid,
    output rw_gen_pkg::fifo_status_t status
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] fill_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    fill_t            fill;
    logic             do_wr;
    logic             do_rd;

    // Wrap explicitly so any depth works
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(DEPTH - 1)) begin
            return '0;
        end else begin
            return p + 1'b1;
        end
    endfunction

    assign do_wr = wr_en & ~status.full;
    assign do_rd = rd_en & ~status.empty;

    assign status.empty     = (fill == '0);
    assign status.full      = (fill == fill_t'(DEPTH));
    assign status.prog_full = (fill >= fill_t'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr & ~do_rd) begin
                fill <= fill + 1'b1;
            end else if (do_rd & ~do_wr) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: rw_gen_setup_ctrl.sv
/*
  Job FSM. A start seen outside idle or done is ignored.
  done stays high from the end of a job until the next start.
*/
`timescale 1ns/100ps
`default_nettype none

module rw_gen_setup_ctrl (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       start,
    input  logic                       config_ready,
    input  rw_gen_pkg::config_packet_t config_in,
    input  logic                       items_done,
    input  logic                       fifos_empty,
    input  logic                       idle_zero,
    input  logic                       req_prog_full,
    output logic                       configure_setup,
    output logic                       param_valid,
    output rw_gen_pkg::rw_config_t     job_config,
    output logic                       done
);

    rw_gen_pkg::gen_state_e state;
    rw_gen_pkg::gen_state_e next_state;
    logic                   drain_clear;
    logic                   start_ok;

    // Job is drained once queues are empty and acks are in (if required)
    assign drain_clear = fifos_empty & (idle_zero | ~job_config.wait_ack);
    assign start_ok    = start & ((state == rw_gen_pkg::GEN_IDLE) |
                                  (state == rw_gen_pkg::GEN_DONE));

    // ------------------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= rw_gen_pkg::GEN_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rw_gen_pkg::GEN_RESET: next_state = rw_gen_pkg::GEN_IDLE;
            rw_gen_pkg::GEN_IDLE: begin
                if (start_ok) next_state = rw_gen_pkg::GEN_SETUP_WAIT;
            end
            rw_gen_pkg::GEN_SETUP_WAIT: begin
                if (config_ready) next_state = rw_gen_pkg::GEN_SETUP_REQ;
            end
            rw_gen_pkg::GEN_SETUP_REQ: next_state = rw_gen_pkg::GEN_SETUP;
            rw_gen_pkg::GEN_SETUP: begin
                if (config_in.valid) next_state = rw_gen_pkg::GEN_START;
            end
            rw_gen_pkg::GEN_START: next_state = rw_gen_pkg::GEN_BUSY;
            rw_gen_pkg::GEN_BUSY: begin
                if (items_done) next_state = rw_gen_pkg::GEN_DRAIN;
                else if (req_prog_full) next_state = rw_gen_pkg::GEN_PAUSE;
            end
            rw_gen_pkg::GEN_PAUSE: begin
                if (items_done) next_state = rw_gen_pkg::GEN_DRAIN;
                else if (!req_prog_full) next_state = rw_gen_pkg::GEN_BUSY;
            end
            rw_gen_pkg::GEN_DRAIN: begin
                if (drain_clear) next_state = rw_gen_pkg::GEN_DONE;
            end
            rw_gen_pkg::GEN_DONE: begin
                // A start right at the end of a job is still taken
                if (start_ok) next_state = rw_gen_pkg::GEN_SETUP_WAIT;
                else next_state = rw_gen_pkg::GEN_IDLE;
            end
            default: next_state = rw_gen_pkg::GEN_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Registered outputs
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            configure_setup <= 1'b0;
            param_valid     <= 1'b0;
            done            <= 1'b0;
        end else begin
            configure_setup <= (state == rw_gen_pkg::GEN_SETUP_REQ);
            param_valid     <= (state == rw_gen_pkg::GEN_START) |
                               (state == rw_gen_pkg::GEN_BUSY)  |
                               (state == rw_gen_pkg::GEN_PAUSE) |
                               (state == rw_gen_pkg::GEN_DRAIN);
            if (start_ok) begin
                done <= 1'b0;
            end else if ((state == rw_gen_pkg::GEN_DRAIN) && drain_clear) begin
                done <= 1'b1;
            end
        end
    end

    // Config held for the whole job
    always_ff @(posedge ap_clk) begin
        if ((state == rw_gen_pkg::GEN_SETUP) && config_in.valid) begin
            job_config <= config_in.cfg;
        end
    end

endmodule

`default_nettype wire

// File: rw_gen_kernel.sv
/*
  Request producer. Pops one input word per cycle while the job is
  active and the request FIFO has room. Three cycles from pop to write.
  Addresses wrap at 32 bits.
*/
`timescale 1ns/100ps
`default_nettype none

module rw_gen_kernel (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     param_valid,
    input  rw_gen_pkg::rw_config_t   job_config,
    input  rw_gen_pkg::data_t        resp_dout,
    input  logic                     resp_valid,
    input  rw_gen_pkg::fifo_status_t resp_status,
    input  logic                     req_prog_full,
    output logic                     resp_rd_en,
    output logic                     req_wr_en,
    output rw_gen_pkg::mem_item_t    req_din,
    output logic                     items_done
);

    rw_gen_pkg::count_t    pop_cnt;
    rw_gen_pkg::count_t    wr_cnt;
    logic                  s1_valid;
    rw_gen_pkg::data_t     s1_data;
    rw_gen_pkg::count_t    s1_idx;
    logic                  s2_valid;
    rw_gen_pkg::mem_item_t s2_item;

    assign resp_rd_en = ~resp_status.empty & param_valid & ~req_prog_full &
                        (pop_cnt < job_config.item_count);

    assign req_wr_en  = s2_valid;
    assign req_din    = s2_item;
    assign items_done = param_valid & (wr_cnt == job_config.item_count);

    // ------------------------------------------------------------------------
    // Pop and write counters, cleared between jobs
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator || !param_valid) begin
            pop_cnt <= '0;
            wr_cnt  <= '0;
        end else begin
            if (resp_rd_en) begin
                pop_cnt <= pop_cnt + 1'b1;
            end
            if (s2_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Two-stage pipeline
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= resp_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        // Stage 1
        if (resp_valid) begin
            s1_data <= resp_dout;
            // pop_cnt already counts the word now on resp_dout
            s1_idx  <= pop_cnt - 1'b1;
        end
        // Stage 2 address is base + index * stride
        if (s1_valid) begin
            s2_item.addr <= job_config.base +
                            rw_gen_pkg::addr_t'(s1_idx) * job_config.stride;
            if (job_config.mode_add) begin
                s2_item.data <= s1_data + job_config.addend;
            end else begin
                s2_item.data <= s1_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rw_gen_issue.sv
/*
  Request consumer. Pops the request FIFO while request_ready is high
  and registers each item out. Acks beyond the outstanding count are
  ignored.
*/
`timescale 1ns/100ps
`default_nettype none

module rw_gen_issue (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  rw_gen_pkg::mem_item_t    req_dout,
    input  logic                     req_valid,
    input  rw_gen_pkg::fifo_status_t req_status,
    input  logic                     request_ready,
    input  logic                     response_memory_in,
    output logic                     req_rd_en,
    output rw_gen_pkg::mem_packet_t  request_memory_out,
    output logic                     idle_zero
);

    rw_gen_pkg::count_t outstanding;
    logic               issue;
    logic               ack;

    assign req_rd_en = ~req_status.empty & request_ready;

    // Count at the pop so the counter never trails the FIFO status
    assign issue     = req_rd_en;
    assign ack       = response_memory_in & (outstanding != '0);
    assign idle_zero = (outstanding == '0);

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_memory_out.valid <= 1'b0;
        end else begin
            request_memory_out.valid <= req_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_valid) begin
            request_memory_out.item <= req_dout;
        end
    end

    // ------------------------------------------------------------------------
    // Outstanding request counter
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            // Issue and ack together leave the count unchanged
            if (issue && !ack) begin
                outstanding <= outstanding + 1'b1;
            end else if (ack && !issue) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rw_gen_top.sv
/*
  Read/write request generator top. The environment must keep at most
  FIFO_DEPTH input words ahead of consumption; further words are lost.
*/
`timescale 1ns/100ps
`default_nettype none

module rw_gen_top #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                       ap_clk,
    input  logic                       areset,
    input  logic                       start,
    input  logic                       config_ready,
    input  rw_gen_pkg::config_packet_t config_in,
    input  rw_gen_pkg::mem_packet_t    response_engine_in,
    input  logic                       request_ready,
    input  logic                       response_memory_in,
    output logic                       configure_setup,
    output rw_gen_pkg::mem_packet_t    request_memory_out,
    output logic                       done
);

    logic                     areset_generator;
    rw_gen_pkg::data_t        resp_dout;
    logic                     resp_valid;
    logic                     resp_rd_en;
    rw_gen_pkg::fifo_status_t resp_status;
    rw_gen_pkg::mem_item_t    req_din;
    rw_gen_pkg::mem_item_t    req_dout;
    logic                     req_valid;
    logic                     req_wr_en;
    logic                     req_rd_en;
    rw_gen_pkg::fifo_status_t req_status;
    rw_gen_pkg::rw_config_t   job_config;
    logic                     param_valid;
    logic                     items_done;
    logic                     idle_zero;
    logic                     fifos_empty;

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    assign fifos_empty = resp_status.empty & req_status.empty;

    // ------------------------------------------------------------------------
    // Input word queue and request queue
    // ------------------------------------------------------------------------
    rw_gen_sync_fifo #(
        .WIDTH($bits(rw_gen_pkg::data_t)), .DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)
    ) resp_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .din(response_engine_in.item.data), .wr_en(response_engine_in.valid),
        .rd_en(resp_rd_en), .dout(resp_dout), .valid(resp_valid), .status(resp_status)
    );

    rw_gen_sync_fifo #(
        .WIDTH($bits(rw_gen_pkg::mem_item_t)), .DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)
    ) req_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .din(req_din), .wr_en(req_wr_en),
        .rd_en(req_rd_en), .dout(req_dout), .valid(req_valid), .status(req_status)
    );

    // ------------------------------------------------------------------------
    // Controller, producer and consumer
    // ------------------------------------------------------------------------
    rw_gen_setup_ctrl u_setup_ctrl (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .start(start),
        .config_ready(config_ready), .config_in(config_in), .items_done(items_done),
        .fifos_empty(fifos_empty), .idle_zero(idle_zero),
        .req_prog_full(req_status.prog_full), .configure_setup(configure_setup),
        .param_valid(param_valid), .job_config(job_config), .done(done)
    );

    rw_gen_kernel u_kernel (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .param_valid(param_valid),
        .job_config(job_config), .resp_dout(resp_dout), .resp_valid(resp_valid),
        .resp_status(resp_status), .req_prog_full(req_status.prog_full),
        .resp_rd_en(resp_rd_en), .req_wr_en(req_wr_en), .req_din(req_din),
        .items_done(items_done)
    );

    rw_gen_issue u_issue (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .req_dout(req_dout),
        .req_valid(req_valid), .req_status(req_status), .request_ready(request_ready),
        .response_memory_in(response_memory_in), .req_rd_en(req_rd_en),
        .request_memory_out(request_memory_out), .idle_zero(idle_zero)
    );

endmodule

`default_nettype wire

// File: tb_rw_gen.sv
/*
  Directed testbench for rw_gen_top. Inputs change on the falling edge
  and outputs are sampled there too. Jobs stay within the FIFO depth.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_rw_gen;

    localparam int NUM_TESTS    = 6;
    localparam int TOTAL_ITEMS  = 4 + 8 + 10 + 12 + 6 + 5;
    localparam int PAUSE_CYCLES = 200;
    localparam int CYCLE_LIMIT  = PAUSE_CYCLES + NUM_TESTS * 100 + TOTAL_ITEMS * 20;

    logic                       ap_clk;
    logic                       areset;
    logic                       start;
    logic                       config_ready;
    rw_gen_pkg::config_packet_t config_in;
    rw_gen_pkg::mem_packet_t    response_engine_in;
    logic                       request_ready;
    logic                       response_memory_in;
    logic                       configure_setup;
    rw_gen_pkg::mem_packet_t    request_memory_out;
    logic                       done;

    rw_gen_pkg::mem_item_t got_q[$];
    rw_gen_pkg::mem_item_t exp_q[$];
    logic [31:0]           rng;
    int                    setup_pulses;
    int                    errors;
    int                    passes;
    int                    cycles;

    rw_gen_top #(
        .FIFO_DEPTH(16), .PROG_THRESH(8)
    ) UUT (
        .ap_clk(ap_clk), .areset(areset), .start(start), .config_ready(config_ready),
        .config_in(config_in), .response_engine_in(response_engine_in),
        .request_ready(request_ready), .response_memory_in(response_memory_in),
        .configure_setup(configure_setup), .request_memory_out(request_memory_out),
        .done(done)
    );

    always #20 ap_clk = ~ap_clk;

    // Run limit
    always @(negedge ap_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rw_gen_pkg::rw_config_t make_cfg(
        input rw_gen_pkg::addr_t base, input rw_gen_pkg::addr_t stride,
        input rw_gen_pkg::count_t n, input logic mode_add,
        input rw_gen_pkg::data_t addend, input logic wait_ack);
        rw_gen_pkg::rw_config_t c;
        c.base       = base;
        c.stride     = stride;
        c.item_count = n;
        c.mode_add   = mode_add;
        c.addend     = addend;
        c.wait_ack   = wait_ack;
        return c;
    endfunction

    // One cycle; outputs are sampled right after the falling edge
    task automatic tick();
        @(negedge ap_clk);
        if (request_memory_out.valid) begin
            got_q.push_back(request_memory_out.item);
        end
        if (configure_setup) begin
            setup_pulses++;
        end
    endtask

    task automatic check_item(input rw_gen_pkg::mem_item_t got,
                              input rw_gen_pkg::mem_item_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h/%h expected %h/%h", $time, what,
                     got.addr, got.data, exp.addr, exp.data);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_count(input rw_gen_pkg::count_t got,
                               input rw_gen_pkg::count_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Job steps
    // ------------------------------------------------------------------------
    task automatic start_job(input rw_gen_pkg::rw_config_t cfg, input int ready_delay);
        got_q.delete();
        exp_q.delete();
        setup_pulses = 0;
        config_ready = (ready_delay == 0);
        start = 1'b1;
        tick();
        start = 1'b0;
        check_done(done, 1'b0, "done after start");
        if (ready_delay > 0) begin
            repeat (ready_delay) tick();
            check_count(rw_gen_pkg::count_t'(setup_pulses), 0, "setup pulses before ready");
        end
        config_ready = 1'b1;
        while (setup_pulses == 0) tick();
        // Config answers the setup request
        config_in.valid = 1'b1;
        config_in.cfg   = cfg;
        tick();
        config_in.valid = 1'b0;
        repeat (4) tick();
        check_count(rw_gen_pkg::count_t'(setup_pulses), 1, "configure_setup pulses");
    endtask

    task automatic send_words(input rw_gen_pkg::rw_config_t cfg);
        rw_gen_pkg::data_t     w;
        rw_gen_pkg::mem_item_t e;
        rw_gen_pkg::addr_t     addr;
        addr = cfg.base;
        for (int i = 0; i < int'(cfg.item_count); i++) begin
            rng = xorshift32(rng);
            w = rng;
            e.addr = addr;
            e.data = cfg.mode_add ? w + cfg.addend : w;
            exp_q.push_back(e);
            addr = addr + cfg.stride;
            response_engine_in.valid     = 1'b1;
            response_engine_in.item.data = w;
            tick();
        end
        response_engine_in.valid = 1'b0;
    endtask

    task automatic collect_and_compare(input int n);
        while (got_q.size() < n) tick();
        // Extra cycles to catch repeated requests
        repeat (10) tick();
        check_count(rw_gen_pkg::count_t'(got_q.size()), n, "request count");
        for (int i = 0; i < n && i < got_q.size(); i++) begin
            check_item(got_q[i], exp_q[i], $sformatf("request %0d", i));
        end
    endtask

    task automatic send_acks(input int n);
        repeat (n) begin
            response_memory_in = 1'b1;
            tick();
        end
        response_memory_in = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) tick();
    endtask

    task automatic report(input string name, input int errors_before);
        $display("%-12s : %0d errors", name, errors - errors_before);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_setup();
        rw_gen_pkg::rw_config_t cfg;
        int                     e0;
        e0  = errors;
        check_done(done, 1'b0, "done after reset");
        check_done(request_memory_out.valid, 1'b0, "request valid after reset");
        cfg = make_cfg(32'h100, 32'd8, 16'd4, 1'b0, '0, 1'b1);
        start_job(cfg, 12);
        send_words(cfg);
        collect_and_compare(4);
        send_acks(4);
        wait_done();
        check_count(rw_gen_pkg::count_t'(setup_pulses), 1, "configure_setup pulses in job");
        report("reset_setup", e0);
    endtask

    task automatic test_job(input string name, input rw_gen_pkg::rw_config_t cfg);
        int e0;
        e0 = errors;
        start_job(cfg, 0);
        send_words(cfg);
        collect_and_compare(int'(cfg.item_count));
        send_acks(int'(cfg.item_count));
        wait_done();
        report(name, e0);
    endtask

    task automatic test_back_pressure();
        rw_gen_pkg::rw_config_t cfg;
        int                     e0;
        e0  = errors;
        cfg = make_cfg(32'h4000, 32'd8, 16'd12, 1'b0, '0, 1'b1);
        request_ready = 1'b0;
        start_job(cfg, 0);
        send_words(cfg);
        repeat (PAUSE_CYCLES) tick();
        check_count(rw_gen_pkg::count_t'(got_q.size()), 0, "requests while stalled");
        request_ready = 1'b1;
        collect_and_compare(12);
        send_acks(12);
        wait_done();
        report("back_pressure", e0);
    endtask

    task automatic test_wait_ack();
        rw_gen_pkg::rw_config_t cfg;
        int                     e0;
        e0  = errors;
        cfg = make_cfg(32'h8000, 32'd16, 16'd6, 1'b1, 32'd1, 1'b1);
        start_job(cfg, 0);
        send_words(cfg);
        collect_and_compare(6);
        check_done(done, 1'b0, "done with no acks");
        send_acks(5);
        repeat (10) tick();
        check_done(done, 1'b0, "done one ack short");
        send_acks(1);
        wait_done();
        repeat (5) tick();
        check_done(done, 1'b1, "done held after job");
        report("wait_ack", e0);
    endtask

    task automatic test_no_ack();
        rw_gen_pkg::rw_config_t cfg;
        int                     e0;
        e0  = errors;
        cfg = make_cfg(32'hff00, 32'd32, 16'd5, 1'b0, '0, 1'b0);
        start_job(cfg, 0);
        send_words(cfg);
        wait_done();
        check_count(rw_gen_pkg::count_t'(got_q.size()), 5, "requests seen at done");
        collect_and_compare(5);
        report("no_ack", e0);
    endtask

    initial begin
        ap_clk             = 1'b0;
        areset             = 1'b1;
        start              = 1'b0;
        config_ready       = 1'b1;
        config_in          = '0;
        response_engine_in = '0;
        request_ready      = 1'b1;
        response_memory_in = 1'b0;
        rng                = 32'hd02f;
        setup_pulses       = 0;
        errors             = 0;
        passes             = 0;
        cycles             = 0;
        repeat (3) tick();
        areset = 1'b0;
        repeat (4) tick();
        test_reset_setup();
        test_job("pass_mode", make_cfg(32'h1000, 32'd4, 16'd8, 1'b0, '0, 1'b1));
        test_job("add_mode", make_cfg(32'h2000_0000, 32'h40, 16'd10, 1'b1,
                                      32'h1234_5678, 1'b1));
        test_back_pressure();
        test_wait_ack();
        test_no_ack();
        $display("checks passed %0d, failed %0d", passes, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rw_gen_pkg.sv
rw_gen_sync_fifo.sv
rw_gen_setup_ctrl.sv
rw_gen_kernel.sv
rw_gen_issue.sv
rw_gen_top.sv
tb_rw_gen.sv
